// ==== src/mport_cfg_pkg.sv ====
package mport_cfg_pkg;

  // Memory geometry
  localparam int WIDTH      = 16;
  localparam int BITADDR    = 6;
  localparam int NUMVBNK    = 4;
  localparam int BITVBNK    = 2;
  localparam int NUMVROW    = 16;
  localparam int BITVROW    = 4;

  // Port counts
  localparam int NUMRDPT    = 2;
  localparam int NUMWRPT    = 2;

  // Write queue
  localparam int QDEPTH     = 8;
  localparam int BITQPTR    = 3;
  localparam int BITQCNT    = 4;
  localparam int BPMAX      = QDEPTH - NUMWRPT;  // Highest threshold that still fits a pair

  localparam int NUMINIT    = NUMVROW;           // One clear cycle per row
  localparam int SRAM_DELAY = 1;

endpackage

// ==== src/mport_types_pkg.sv ====
package mport_types_pkg;

  import mport_cfg_pkg::*;

  // Low bits pick the bank, the rest is the row inside it
  typedef struct packed {
    logic [BITVROW-1:0] row;
    logic [BITVBNK-1:0] bank;
  } addr_fields_t;

  typedef union packed {
    logic [BITADDR-1:0] flat;
    addr_fields_t       fields;
  } mem_addr_u;

  // One queued write
  typedef struct packed {
    mem_addr_u        addr;
    logic [WIDTH-1:0] data;
  } wr_entry_t;

endpackage

// ==== src/mport_bank_if.sv ====
interface mport_bank_if
  import mport_cfg_pkg::*;
();

  // Write side, one lane per bank
  logic [NUMVBNK-1:0] wr_en;
  logic [BITVROW-1:0] wr_row  [NUMVBNK];
  logic [WIDTH-1:0]   wr_data [NUMVBNK];

  // Read side, one lane per read port
  logic [NUMRDPT-1:0] rd_en;
  logic [BITVBNK-1:0] rd_bank [NUMRDPT];
  logic [BITVROW-1:0] rd_row  [NUMRDPT];
  logic [WIDTH-1:0]   rd_data [NUMRDPT];

  modport writer (output wr_en, output wr_row, output wr_data);

  modport reader (output rd_en, output rd_bank, output rd_row, input rd_data);

  modport array (
    input  wr_en, wr_row, wr_data,
    input  rd_en, rd_bank, rd_row,
    output rd_data
  );

endinterface

// ==== src/mport_write_queue.sv ====
module mport_write_queue
  import mport_cfg_pkg::*, mport_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [NUMWRPT-1:0]       push,
  input  wr_entry_t                push_entry [NUMWRPT],
  input  logic [1:0]               pop_cnt,
  output wr_entry_t                head0,
  output wr_entry_t                head1,
  output logic [BITQCNT-1:0]       count,
  input  mem_addr_u                rd_lookup_adr [NUMRDPT],
  output logic [NUMRDPT-1:0]       fwd_hit,
  output logic [NUMRDPT*WIDTH-1:0] fwd_data
);

  wr_entry_t          mem [QDEPTH];
  logic [BITQPTR-1:0] wptr;
  logic [BITQPTR-1:0] rptr;
  logic [BITQPTR-1:0] rptr1;
  logic [BITQPTR-1:0] slot1;

  // Port 1 lands behind port 0 when both push
  assign slot1 = wptr + BITQPTR'(push[0]);
  assign rptr1 = rptr + 1'b1;

  always_ff @(posedge clk) begin
    if (push[0]) begin
      mem[wptr] <= push_entry[0];
    end
    if (push[1]) begin
      mem[slot1] <= push_entry[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + BITQPTR'(push[0]) + BITQPTR'(push[1]);
      rptr  <= rptr + BITQPTR'(pop_cnt);
      count <= count + BITQCNT'(push[0]) + BITQCNT'(push[1]) - BITQCNT'(pop_cnt);
    end
  end

  assign head0 = mem[rptr];
  assign head1 = mem[rptr1];  // Only meaningful with two or more entries

  // Scan oldest to youngest, so the last hit is the youngest write
  always_comb begin
    logic [BITQPTR-1:0] idx;
    idx      = '0;
    fwd_hit  = '0;
    fwd_data = '0;
    for (int r = 0; r < NUMRDPT; r++) begin
      for (int i = 0; i < QDEPTH; i++) begin
        idx = rptr + BITQPTR'(i);
        if ((BITQCNT'(i) < count) &&
            (mem[idx].addr.flat == rd_lookup_adr[r].flat)) begin
          fwd_hit[r]                 = 1'b1;
          fwd_data[r*WIDTH +: WIDTH] = mem[idx].data;
        end
      end
    end
  end

endmodule

// ==== src/mport_ctrl.sv ====
module mport_ctrl
  import mport_cfg_pkg::*, mport_types_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [3:0]                 bp_thr,
  output logic                       ready,
  output logic                       wr_bp,
  output logic [NUMWRPT-1:0]         push,
  output wr_entry_t                  push_entry [NUMWRPT],
  output logic [1:0]                 pop_cnt,
  input  wr_entry_t                  head0,
  input  wr_entry_t                  head1,
  input  logic [BITQCNT-1:0]         count,
  mport_bank_if.writer               bank
);

  logic               init_on;
  logic [BITVROW-1:0] init_row;
  logic [3:0]         thr;
  logic               pop0;
  logic               pop1;

  // Init sweep starts the cycle after reset is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      init_on  <= 1'b0;
      init_row <= '0;
      ready    <= 1'b0;
    end else if (init_on) begin
      init_row <= init_row + 1'b1;
      if (init_row == BITVROW'(NUMINIT - 1)) begin
        init_on <= 1'b0;
        ready   <= 1'b1;
      end
    end else if (!ready) begin
      init_on <= 1'b1;
    end
  end

  // Thresholds above the pair limit are clamped
  assign thr   = (bp_thr > 4'(BPMAX)) ? 4'(BPMAX) : bp_thr;
  assign wr_bp = !ready || (count >= thr);

  for (genvar p = 0; p < NUMWRPT; p++) begin : g_push
    assign push[p]       = write[p] && ready && !wr_bp;
    assign push_entry[p] = '{addr: wr_adr[p*BITADDR +: BITADDR],
                             data: din[p*WIDTH +: WIDTH]};
  end

  // Second head only goes along when it hits another bank
  always_comb begin
    pop0 = ready && (count != '0);
    pop1 = pop0 && (count > BITQCNT'(1)) &&
           (head1.addr.fields.bank != head0.addr.fields.bank);
  end

  assign pop_cnt = {1'b0, pop0} + {1'b0, pop1};

  always_comb begin
    for (int b = 0; b < NUMVBNK; b++) begin
      bank.wr_en[b]   = 1'b0;
      bank.wr_row[b]  = init_row;
      bank.wr_data[b] = '0;
      if (init_on) begin
        bank.wr_en[b] = 1'b1;                     // Clear this row everywhere
      end else if (pop0 && (head0.addr.fields.bank == BITVBNK'(b))) begin
        bank.wr_en[b]   = 1'b1;
        bank.wr_row[b]  = head0.addr.fields.row;
        bank.wr_data[b] = head0.data;
      end else if (pop1 && (head1.addr.fields.bank == BITVBNK'(b))) begin
        bank.wr_en[b]   = 1'b1;
        bank.wr_row[b]  = head1.addr.fields.row;
        bank.wr_data[b] = head1.data;
      end
    end
  end

endmodule

// ==== src/mport_bank_array.sv ====
module mport_bank_array
  import mport_cfg_pkg::*;
(
  input logic         clk,
  mport_bank_if.array bank
);

  // One copy per read port inside every bank
  logic [WIDTH-1:0] mem     [NUMVBNK][NUMRDPT][NUMVROW];
  logic [WIDTH-1:0] rd_pipe [NUMRDPT][SRAM_DELAY];

  // A write goes to every copy of its bank
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUMVBNK; b++) begin
      if (bank.wr_en[b]) begin
        for (int r = 0; r < NUMRDPT; r++) begin
          mem[b][r][bank.wr_row[b]] <= bank.wr_data[b];
        end
      end
    end
  end

  // Read port r only ever touches copy r, so ports never collide
  always_ff @(posedge clk) begin
    for (int r = 0; r < NUMRDPT; r++) begin
      if (bank.rd_en[r]) begin
        rd_pipe[r][0] <= mem[bank.rd_bank[r]][r][bank.rd_row[r]];
      end
      for (int s = 1; s < SRAM_DELAY; s++) begin
        rd_pipe[r][s] <= rd_pipe[r][s-1];
      end
    end
  end

  for (genvar r = 0; r < NUMRDPT; r++) begin : g_rd
    assign bank.rd_data[r] = rd_pipe[r][SRAM_DELAY-1];
  end

endmodule

// ==== src/mport_read_path.sv ====
module mport_read_path
  import mport_cfg_pkg::*, mport_types_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ready,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output mem_addr_u                  rd_lookup_adr [NUMRDPT],
  input  logic [NUMRDPT-1:0]         fwd_hit,
  input  logic [NUMRDPT*WIDTH-1:0]   fwd_data,
  mport_bank_if.reader               bank,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout
);

  logic [NUMRDPT-1:0]       hit_q;
  logic [NUMRDPT*WIDTH-1:0] fwd_q;

  for (genvar r = 0; r < NUMRDPT; r++) begin : g_port
    assign rd_lookup_adr[r].flat = rd_adr[r*BITADDR +: BITADDR];

    // Bank and row straight from the address fields
    assign bank.rd_en[r]   = read[r] && ready;
    assign bank.rd_bank[r] = rd_lookup_adr[r].fields.bank;
    assign bank.rd_row[r]  = rd_lookup_adr[r].fields.row;

    // Queued data is newer than anything in the banks
    assign rd_dout[r*WIDTH +: WIDTH] = hit_q[r] ? fwd_q[r*WIDTH +: WIDTH] : bank.rd_data[r];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= read & {NUMRDPT{ready}};
    end
  end

  // Lines up with the bank read latency
  always_ff @(posedge clk) begin
    hit_q <= fwd_hit;
    fwd_q <= fwd_data;
  end

endmodule

// ==== src/mport_top.sv ====
module mport_top
  import mport_cfg_pkg::*, mport_types_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  output logic                       ready,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [3:0]                 bp_thr,
  output logic                       wr_bp,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout
);

  logic [NUMWRPT-1:0]       push;
  wr_entry_t                push_entry [NUMWRPT];
  logic [1:0]               pop_cnt;
  wr_entry_t                head0;
  wr_entry_t                head1;
  logic [BITQCNT-1:0]       count;
  mem_addr_u                rd_lookup_adr [NUMRDPT];
  logic [NUMRDPT-1:0]       fwd_hit;
  logic [NUMRDPT*WIDTH-1:0] fwd_data;

  mport_bank_if bank_if ();

  mport_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .write(write), .wr_adr(wr_adr), .din(din), .bp_thr(bp_thr),
    .ready(ready), .wr_bp(wr_bp),
    .push(push), .push_entry(push_entry), .pop_cnt(pop_cnt),
    .head0(head0), .head1(head1), .count(count),
    .bank(bank_if.writer)
  );

  mport_write_queue u_queue (
    .clk(clk), .rst_n(rst_n),
    .push(push), .push_entry(push_entry), .pop_cnt(pop_cnt),
    .head0(head0), .head1(head1), .count(count),
    .rd_lookup_adr(rd_lookup_adr), .fwd_hit(fwd_hit), .fwd_data(fwd_data)
  );

  mport_bank_array u_banks (
    .clk(clk),
    .bank(bank_if.array)
  );

  mport_read_path u_read (
    .clk(clk), .rst_n(rst_n), .ready(ready),
    .read(read), .rd_adr(rd_adr),
    .rd_lookup_adr(rd_lookup_adr), .fwd_hit(fwd_hit), .fwd_data(fwd_data),
    .bank(bank_if.reader),
    .rd_vld(rd_vld), .rd_dout(rd_dout)
  );

endmodule

// ==== verif/mport_tb.sv ====
module mport_tb
  import mport_cfg_pkg::*;
();

  localparam int MAX_CYCLES = 4000;  // Roughly 750 cycles of tests plus a wide margin
  localparam logic [31:0] SEED = 32'h905aa87f;

  logic                       clk;
  logic                       rst_n;
  logic                       ready;
  logic [NUMWRPT-1:0]         write;
  logic [NUMWRPT*BITADDR-1:0] wr_adr;
  logic [NUMWRPT*WIDTH-1:0]   din;
  logic [3:0]                 bp_thr;
  logic                       wr_bp;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;

  // Reference memory and the read results owed for the next cycle
  logic [WIDTH-1:0]   model [64];
  logic [NUMRDPT-1:0] exp_vld;
  logic [WIDTH-1:0]   exp_data [NUMRDPT];
  logic [NUMWRPT-1:0] last_acc;
  logic               last_bp;
  logic               ready_seen;
  logic [3:0]         thr_set;
  string              test_name;
  int                 cycle_cnt;

  mport_top u_dut (
    .clk(clk), .rst_n(rst_n), .ready(ready),
    .write(write), .wr_adr(wr_adr), .din(din), .bp_thr(bp_thr),
    .wr_bp(wr_bp),
    .read(read), .rd_adr(rd_adr),
    .rd_vld(rd_vld), .rd_dout(rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run exceeded %0d cycles without finishing", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check(input string label, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("CHECK FAILED test=%s %s expected=0x%h actual=0x%h",
               test_name, label, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // One clock of stimulus; judges acceptance and checks last cycle's reads
  task automatic cycle(input logic [1:0] w,
                       input logic [5:0] wa0, input logic [15:0] d0,
                       input logic [5:0] wa1, input logic [15:0] d1,
                       input logic [1:0] r,
                       input logic [5:0] ra0, input logic [5:0] ra1);
    logic [1:0] acc;
    @(posedge clk);
    write  <= w;
    wr_adr <= {wa1, wa0};
    din    <= {d1, d0};
    read   <= r;
    rd_adr <= {ra1, ra0};
    bp_thr <= thr_set;
    @(negedge clk);
    for (int p = 0; p < NUMRDPT; p++) begin
      check("rd_vld", 32'(exp_vld[p]), 32'(rd_vld[p]));
      if (exp_vld[p]) begin
        check("rd_dout", 32'(exp_data[p]), 32'(rd_dout[p*WIDTH +: WIDTH]));
      end
    end
    if (ready_seen) check("ready after init", 32'd1, 32'(ready));
    acc         = w & {2{!wr_bp}};
    exp_vld     = r & {2{ready_seen}};  // Reads only count once init is done
    exp_data[0] = model[ra0];           // Value before this cycle's writes
    exp_data[1] = model[ra1];
    if (acc[0]) model[wa0] = d0;
    if (acc[1]) model[wa1] = d1;        // Port 1 lands last
    last_acc = acc;
    last_bp  = wr_bp;
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(2'b00, 6'd0, 16'd0, 6'd0, 16'd0, 2'b00, 6'd0, 6'd0);
  endtask

  task automatic write_pair(input logic [5:0] a0, input logic [15:0] d0,
                            input logic [5:0] a1, input logic [15:0] d1);
    cycle(2'b11, a0, d0, a1, d1, 2'b00, 6'd0, 6'd0);
  endtask

  task automatic read_pair(input logic [5:0] a0, input logic [5:0] a1);
    cycle(2'b00, 6'd0, 16'd0, 6'd0, 16'd0, 2'b11, a0, a1);
  endtask

  task automatic readback_all();
    for (int i = 0; i < 32; i++) begin
      read_pair(6'(2*i), 6'(2*i+1));
    end
    idle(1);
  endtask

  task automatic init_check();
    int waited;
    test_name = "init_check";
    waited    = 0;
    do begin
      idle(1);
      waited++;
      if (!ready) check("wr_bp before ready", 32'd1, 32'(wr_bp));
    end while (!ready && waited < 40);
    if (!ready) begin
      $display("ready did not rise within 40 cycles of reset release");
      $display("Simulation failed");
      $fatal(1, "init did not finish");
    end
    ready_seen = 1'b1;
    readback_all();
  endtask

  task automatic write_readback();
    logic [5:0] adr [8];
    test_name = "write_readback";
    adr = '{6'd3, 6'd12, 6'd17, 6'd30, 6'd40, 6'd45, 6'd58, 6'd63};
    for (int k = 0; k < 4; k++) begin
      write_pair(adr[2*k], 16'($urandom), adr[2*k+1], 16'($urandom));
      check("write accepted", 32'd3, 32'(last_acc));
    end
    idle(10);
    for (int k = 0; k < 4; k++) begin
      read_pair(adr[2*k], adr[2*k+1]);
    end
    idle(1);
  endtask

  task automatic forwarding();
    logic [5:0] a0;
    logic [5:0] a1;
    test_name = "forwarding";
    for (int k = 0; k < 4; k++) begin
      a0 = {4'(k), 2'b01};    // Both in bank 1 so the queue backs up
      a1 = {4'(k+8), 2'b01};
      write_pair(a0, 16'($urandom), a1, 16'($urandom));
      read_pair(a0, a1);
    end
    idle(1);
  endtask

  task automatic same_address();
    test_name = "same_address";
    write_pair(6'd21, 16'h1111, 6'd21, 16'h2222);
    check("write accepted", 32'd3, 32'(last_acc));
    read_pair(6'd21, 6'd21);  // Still queued
    idle(5);
    read_pair(6'd21, 6'd21);
    idle(1);
  endtask

  task automatic backpressure();
    int rise_at;
    int waited;
    test_name = "backpressure";
    thr_set   = 4'd4;
    rise_at   = 0;
    for (int i = 0; i < 12; i++) begin
      write_pair({4'(2*i), 2'b00}, 16'($urandom), {4'(2*i+1), 2'b00}, 16'($urandom));
      if (last_bp && rise_at == 0) rise_at = i + 1;
    end
    if (rise_at == 0 || rise_at > 8) begin
      $display("wr_bp did not rise within 8 cycles of a bank 0 write stream");
      $display("Simulation failed");
      $fatal(1, "no back-pressure");
    end
    waited = 0;
    do begin
      idle(1);
      waited++;
    end while (last_bp && waited < 10);
    if (last_bp) begin
      $display("wr_bp stayed high 10 cycles after the writes stopped");
      $display("Simulation failed");
      $fatal(1, "back-pressure stuck");
    end
    readback_all();
    thr_set = 4'd6;
  endtask

  task automatic random_mix();
    test_name = "random_mix";
    for (int i = 0; i < 500; i++) begin
      thr_set = 4'($urandom_range(15, 1));
      cycle(2'($urandom), 6'($urandom), 16'($urandom), 6'($urandom), 16'($urandom),
            2'($urandom), 6'($urandom), 6'($urandom));
    end
    thr_set = 4'd6;
    idle(10);
    readback_all();
  endtask

  initial begin
    void'($urandom(SEED));
    cycle_cnt  = 0;
    exp_vld    = '0;
    last_acc   = '0;
    last_bp    = 1'b0;
    ready_seen = 1'b0;
    thr_set    = 4'd6;
    test_name  = "reset";
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;                    // Init sweep clears every row
    end
    rst_n  <= 1'b0;
    write  <= '0;
    wr_adr <= '0;
    din    <= '0;
    bp_thr <= 4'd6;
    read   <= '0;
    rd_adr <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    init_check();
    write_readback();
    forwarding();
    same_address();
    backpressure();
    random_mix();
    idle(2);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== mport.f ====
src/mport_cfg_pkg.sv
src/mport_types_pkg.sv
src/mport_bank_if.sv
src/mport_write_queue.sv
src/mport_ctrl.sv
src/mport_bank_array.sv
src/mport_read_path.sv
src/mport_top.sv
verif/mport_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mport testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module mport_tb \
  -f mport.f \
  -o mport_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/mport_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit "$status"
fi

exit 0
